//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tspp_execute_stage_tb
FILELIST  := tspp_exec.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/alu.sv
// RV32I ALU
// Arithmetic, logic, shifts and set-less-than compares

`timescale 1ns/100ps

module alu (
    input  rv32_pkg::aluop_t aluop,
    input  rv32_pkg::word_t  port_a,
    input  rv32_pkg::word_t  port_b,
    output rv32_pkg::word_t  port_out
);

    import rv32_pkg::*;

    logic [4:0] shamt;

    assign shamt = port_b[4:0];

    always_comb begin
        case (aluop)
            ALU_ADD:  port_out = port_a + port_b;
            ALU_SUB:  port_out = port_a - port_b;
            ALU_SLL:  port_out = port_a << shamt;
            ALU_SRL:  port_out = port_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
            ALU_SLT:  port_out = word_t'($signed(port_a) < $signed(port_b));
            ALU_SLTU: port_out = word_t'(port_a < port_b);
            ALU_XOR:  port_out = port_a ^ port_b;
            ALU_OR:   port_out = port_a | port_b;
            ALU_AND:  port_out = port_a & port_b;
            default:  port_out = '0;
        endcase
    end

endmodule

//--- hdl/branch_res.sv
// Conditional branch resolution
// Compares the two sources and forms the pc-relative target

`timescale 1ns/100ps

module branch_res (
    input  rv32_pkg::word_t   rs1_data,
    input  rv32_pkg::word_t   rs2_data,
    input  rv32_pkg::word_t   pc,
    input  logic [12:0]       imm_sb,
    input  rv32_pkg::branch_t branch_type,
    output logic              branch_taken,
    output rv32_pkg::word_t   branch_addr
);

    import rv32_pkg::*;

    word_t offset;

    assign offset      = {{19{imm_sb[12]}}, imm_sb};
    assign branch_addr = pc + offset;

    always_comb begin
        case (branch_type)
            BEQ:     branch_taken = (rs1_data == rs2_data);
            BNE:     branch_taken = (rs1_data != rs2_data);
            BLT:     branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            BGE:     branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU:    branch_taken = (rs1_data < rs2_data);
            BGEU:    branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- hdl/control_unit.sv
// RV32I instruction decoder
// Produces selects, enables and sign-extended immediates for one instruction

`timescale 1ns/100ps

`include "tspp_params.svh"

module control_unit (
    input  rv32_pkg::word_t instr,
    output rv32_pkg::ctrl_t ctrl
);

    import rv32_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl = '0;
        ctrl.rs1 = instr[19:15];
        ctrl.rs2 = instr[24:20];
        ctrl.rd  = instr[11:7];
        ctrl.imm_I  = {{20{instr[31]}}, instr[31:20]};
        ctrl.imm_S  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        ctrl.imm_SB = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        ctrl.imm_UJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        ctrl.imm_U  = {instr[31:12], 12'b0};
        ctrl.load_type   = load_t'(funct3);
        ctrl.branch_type = branch_t'(funct3);
        ctrl.alu_op = ALU_ADD;
        ctrl.w_sel  = 2'd3;
        legal = 1'b1;

        case (opcode)
            OP_LUI: begin
                ctrl.wen   = 1'b1;
                ctrl.w_sel = 2'd2;
            end
            OP_AUIPC: begin
                ctrl.wen       = 1'b1;
                ctrl.alu_a_sel = 2'd2;
                ctrl.alu_b_sel = 2'd3;
            end
            OP_JAL, OP_JALR: begin
                ctrl.wen       = 1'b1;
                ctrl.w_sel     = 2'd1;
                ctrl.jump      = 1'b1;
                ctrl.ex_pc_sel = 1'b1;
                ctrl.j_sel     = (opcode == OP_JAL);
                if (opcode == OP_JALR && funct3 != 3'b000)
                    legal = 1'b0;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                legal = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            OP_LOAD: begin
                ctrl.dren      = 1'b1;
                ctrl.wen       = 1'b1;
                ctrl.w_sel     = 2'd0;
                ctrl.alu_b_sel = 2'd2;
                legal = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            end
            OP_STORE: begin
                // Address is imm_S plus rs1
                ctrl.dwen      = 1'b1;
                ctrl.alu_a_sel = 2'd1;
                ctrl.alu_b_sel = 2'd0;
                legal = (funct3 <= 3'b010);
            end
            OP_IMM, OP_REG: begin
                ctrl.wen       = 1'b1;
                ctrl.alu_b_sel = (opcode == OP_IMM) ? 2'd2 : 2'd1;
                case (funct3)
                    3'b000: ctrl.alu_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
                ctrl.imm_shamt_sel = (opcode == OP_IMM) && (funct3 inside {3'b001, 3'b101});
                // funct7 is only checked where it is a real field
                if (opcode == OP_REG || ctrl.imm_shamt_sel) begin
                    if (funct7 == 7'b0100000)
                        legal = (funct3 == 3'b101) ||
                                (opcode == OP_REG && funct3 == 3'b000);
                    else
                        legal = (funct7 == 7'b0000000);
                end
            end
            default: legal = 1'b0;
        endcase

        if (instr == `HALT_INSN) begin
            ctrl.halt = 1'b1;
            legal = 1'b1;
        end

        if (!legal) begin
            ctrl.wen       = 1'b0;
            ctrl.dren      = 1'b0;
            ctrl.dwen      = 1'b0;
            ctrl.branch    = 1'b0;
            ctrl.jump      = 1'b0;
            ctrl.ex_pc_sel = 1'b0;
        end
        ctrl.illegal_insn = ~legal;
    end

endmodule

//--- hdl/dmem_lanes.sv
// Data bus lane logic, little-endian
// Byte enables, store replication, load extension and alignment check

`timescale 1ns/100ps

module dmem_lanes (
    input  rv32_pkg::word_t     addr,
    input  rv32_pkg::word_t     store_data,
    input  rv32_pkg::load_t     load_type,
    input  logic                dren,
    input  logic                dwen,
    input  rv32_pkg::word_t     rdata,
    output rv32_pkg::dbus_req_t req,
    output rv32_pkg::word_t     load_out,
    output logic                mal_addr
);

    import rv32_pkg::*;

    logic [1:0] offset;
    logic [7:0] lane_b;
    logic [15:0] lane_h;
    logic       misaligned;

    assign offset = addr[1:0];

    always_comb begin
        case (load_type)
            LB, LBU: begin
                req.byte_en = 4'b0001 << offset;
                req.wdata   = {4{store_data[7:0]}};
                misaligned  = 1'b0;
            end
            LH, LHU: begin
                req.byte_en = offset[1] ? 4'b1100 : 4'b0011;
                req.wdata   = {2{store_data[15:0]}};
                misaligned  = offset[0];
            end
            default: begin
                req.byte_en = 4'b1111;
                req.wdata   = store_data;
                misaligned  = (offset != 2'b00);
            end
        endcase
    end

    assign mal_addr = (dren | dwen) & misaligned;
    assign req.addr = addr;
    assign req.ren  = dren & ~misaligned;
    assign req.wen  = dwen & ~misaligned;

    // Pick the addressed lane before extending
    assign lane_b = rdata[8*offset +: 8];
    assign lane_h = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (load_type)
            LB:      load_out = {{24{lane_b[7]}}, lane_b};
            LBU:     load_out = {24'b0, lane_b};
            LH:      load_out = {{16{lane_h[15]}}, lane_h};
            LHU:     load_out = {16'b0, lane_h};
            default: load_out = rdata;
        endcase
    end

endmodule

//--- hdl/reg_file.sv
// Integer register file
// Two combinational read ports and one clocked write port, x0 reads zero

`timescale 1ns/100ps

`include "tspp_params.svh"

module reg_file (
    input  logic              CLK,
    input  logic              nRST,
    input  rv32_pkg::regsel_t rs1,
    input  rv32_pkg::regsel_t rs2,
    output rv32_pkg::word_t   rs1_data,
    output rv32_pkg::word_t   rs2_data,
    input  rv32_pkg::wb_t     wb
);

    import rv32_pkg::*;

    word_t regs [`NREGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wb.wen && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // No bypass from the write port
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- hdl/rv32_pkg.sv
// RV32I shared types
// Opcodes, ALU and access encodings, and the stage's bus structs

package rv32_pkg;

    `include "tspp_params.svh"

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [4:0] regsel_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } aluop_t;

    // Values are funct3, shared by loads and stores
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_t;

    typedef struct packed {
        word_t pc;
        word_t pc4;
        word_t instr;
        logic  prediction;
    } fetch_ex_t;

    typedef struct packed {
        regsel_t     rs1, rs2, rd;
        aluop_t      alu_op;
        logic [1:0]  alu_a_sel, alu_b_sel, w_sel;
        logic        imm_shamt_sel;
        logic        wen, dren, dwen;
        logic        branch;
        branch_t     branch_type;
        logic        jump, j_sel, ex_pc_sel;
        load_t       load_type;
        word_t       imm_I, imm_S;
        logic [12:0] imm_SB;
        word_t       imm_UJ, imm_U;
        logic        halt, illegal_insn;
    } ctrl_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
        logic       ren, wen;
    } dbus_req_t;

    typedef struct packed {
        regsel_t rd;
        word_t   data;
        logic    wen;
    } wb_t;

    typedef struct packed {
        logic  mal_l, mal_s, illegal;
        word_t badaddr;
    } exc_t;

endpackage

//--- hdl/tspp_execute_stage.sv
// Execute stage of the two-stage RV32I pipeline
// Decode, register read, ALU, branch and jump resolution, data bus and write-back

`timescale 1ns/100ps

module tspp_execute_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  rv32_pkg::fetch_ex_t fetch_ex,
    input  logic                in_valid,
    output logic                in_ready,
    output rv32_pkg::dbus_req_t dbus,
    input  logic                dmem_ready,
    input  rv32_pkg::word_t     rdata,
    output rv32_pkg::wb_t       wb,
    output rv32_pkg::word_t     brj_addr,
    output logic                mispredict,
    output rv32_pkg::exc_t      exc,
    output logic                halt
);

    import rv32_pkg::*;

    ctrl_t ctrl;
    word_t rs1_data, rs2_data;
    word_t port_a, port_b, alu_out;
    word_t load_out, branch_addr, jump_addr;
    logic  br_cond, taken, mal_addr;
    logic  out_rst, go, mem_wait, accept;

    control_unit cu0 (.instr(fetch_ex.instr), .ctrl(ctrl));

    // Register file sits beside the datapath it feeds
    reg_file rf0 (
        .CLK, .nRST, .rs1(ctrl.rs1), .rs2(ctrl.rs2),
        .rs1_data, .rs2_data, .wb
    );

    always_comb begin
        case (ctrl.alu_a_sel)
            2'd0:    port_a = rs1_data;
            2'd1:    port_a = ctrl.imm_S;
            2'd2:    port_a = fetch_ex.pc;
            default: port_a = '0;
        endcase
        case (ctrl.alu_b_sel)
            2'd0:    port_b = rs1_data;
            2'd1:    port_b = rs2_data;
            2'd2:    port_b = ctrl.imm_shamt_sel ? {27'b0, ctrl.imm_I[4:0]} : ctrl.imm_I;
            default: port_b = ctrl.imm_U;
        endcase
    end

    alu alu0 (.aluop(ctrl.alu_op), .port_a, .port_b, .port_out(alu_out));

    branch_res br0 (
        .rs1_data, .rs2_data, .pc(fetch_ex.pc), .imm_sb(ctrl.imm_SB),
        .branch_type(ctrl.branch_type), .branch_taken(br_cond), .branch_addr
    );

    // JALR target drops bit 0
    assign jump_addr = ctrl.j_sel ? fetch_ex.pc + ctrl.imm_UJ
                                  : (rs1_data + ctrl.imm_I) & ~word_t'(1);
    assign taken      = ctrl.branch & br_cond;
    assign brj_addr   = ctrl.ex_pc_sel ? jump_addr : (taken ? branch_addr : fetch_ex.pc4);
    assign mispredict = fetch_ex.prediction ^ (ctrl.jump | taken);

    // Stage is idle out of reset and after halt
    assign go = in_valid & out_rst & ~halt;

    dmem_lanes dl0 (
        .addr(alu_out), .store_data(rs2_data), .load_type(ctrl.load_type),
        .dren(go & ctrl.dren), .dwen(go & ctrl.dwen), .rdata,
        .req(dbus), .load_out, .mal_addr
    );

    assign mem_wait = (dbus.ren | dbus.wen) & ~dmem_ready;
    assign in_ready = out_rst & ~halt & ~mem_wait;
    assign accept   = in_valid & in_ready;

    always_comb begin
        case (ctrl.w_sel)
            2'd0:    wb.data = load_out;
            2'd1:    wb.data = fetch_ex.pc4;
            2'd2:    wb.data = ctrl.imm_U;
            default: wb.data = alu_out;
        endcase
    end

    assign wb.rd  = ctrl.rd;
    assign wb.wen = accept & ctrl.wen & ~mal_addr & (ctrl.rd != '0);

    assign exc.mal_l   = go & ctrl.dren & mal_addr;
    assign exc.mal_s   = go & ctrl.dwen & mal_addr;
    assign exc.illegal = go & ctrl.illegal_insn;
    assign exc.badaddr = alu_out;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_rst <= 1'b0;
            halt    <= 1'b0;
        end else begin
            out_rst <= 1'b1;
            if (accept && ctrl.halt)
                halt <= 1'b1;
        end
    end

endmodule

//--- hdl/tspp_params.svh
// Execute stage parameters
// Word width, register count and the halt instruction word

`ifndef TSPP_PARAMS_SVH
`define TSPP_PARAMS_SVH

// Data and address width
`define WORD_W 32

// Architectural registers, x0 included
`define NREGS 32

// All ones never decodes as a valid RV32I word
`define HALT_INSN 32'hFFFFFFFF

`endif

//--- testbench/tspp_execute_stage_chk.sv
// Execute stage protocol checks
// Handshake, bus and write-back assertions bound into the stage

`timescale 1ns/100ps

`include "tspp_params.svh"

module tspp_execute_stage_chk (
    input logic                CLK,
    input logic                nRST,
    input rv32_pkg::fetch_ex_t fetch_ex,
    input logic                in_valid,
    input logic                in_ready,
    input logic                halt,
    input logic                dmem_ready,
    input rv32_pkg::dbus_req_t dbus,
    input rv32_pkg::wb_t       wb
);

    import rv32_pkg::*;

    // Halt sets on acceptance of the halt word and parks the stage
    a_halt_ready: assert property (@(posedge CLK) disable iff (!nRST)
        (halt || (in_valid && in_ready && fetch_ex.instr == `HALT_INSN))
        |=> (halt && !in_ready))
        else $error("halt not held or in_ready high while halted");

    a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!nRST) !(dbus.ren && dbus.wen))
        else $error("ren and wen both high");

    // rd field taken straight from the instruction word
    a_wb_x0: assert property (@(posedge CLK) disable iff (!nRST)
        wb.wen |-> (fetch_ex.instr[11:7] != '0) && (wb.rd == fetch_ex.instr[11:7]))
        else $error("write-back to x0 or to the wrong register");

    // Request held steady across a stall
    a_bus_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (in_valid && (dbus.ren || dbus.wen) && !dmem_ready) |=> $stable(dbus))
        else $error("dbus changed while stalled");

endmodule

bind tspp_execute_stage tspp_execute_stage_chk chk0 (.*);

//--- testbench/tspp_execute_stage_tb.sv
// Execute stage testbench
// Table of RV32I instructions against a data memory model and reference registers

`timescale 1ns/100ps

`include "tspp_params.svh"

module tspp_execute_stage_tb;

    import rv32_pkg::*;

    localparam int RST_CYCLES = 16;
    localparam int K_WR = 0, K_ST = 1, K_LD = 2, K_MAL_L = 3, K_MAL_S = 4, K_ILL = 5, K_HALT = 6;

    logic      CLK, nRST, in_valid, in_ready, dmem_ready, mispredict, halt;
    fetch_ex_t fetch_ex;
    dbus_req_t dbus;
    word_t     rdata, brj_addr;
    wb_t       wb;
    exc_t      exc;

    word_t      mem [64];
    word_t      ref_mem [64];
    word_t      ref_regs [`NREGS];
    string      t_name [$];
    word_t      t_instr [$], t_pc [$], t_exp [$], t_maddr [$], t_brj [$];
    logic       t_pred [$], t_misp [$];
    logic [3:0] t_be [$];
    int         t_kind [$];
    regsel_t    t_rd [$];
    int         errors = 0, checks = 0, cycles = 0, limit = 1000000;
    int         wb_count = 0, wb_expected = 0;

    tspp_execute_stage dut0 (.*);

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    // Combinational read, byte-lane write when the request is accepted
    assign rdata = mem[dbus.addr[7:2]];
    always @(posedge CLK) begin
        if (in_valid && dmem_ready && dbus.wen) begin
            for (int b = 0; b < 4; b++)
                if (dbus.byte_en[b])
                    mem[dbus.addr[7:2]][8*b +: 8] <= dbus.wdata[8*b +: 8];
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (wb.wen)
            wb_count++;
        if (cycles > limit) begin
            $display("Timeout: run went past %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic word_t fill(int idx);
        return word_t'(idx * 32'h01000193) ^ 32'hC0DE0000 ^ word_t'(idx << 2);
    endfunction

    function automatic word_t enc_i(int imm, regsel_t rs1, logic [2:0] f3, regsel_t rd,
                                    logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, regsel_t rs2, regsel_t rs1,
                                    logic [2:0] f3, regsel_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_s(int imm, regsel_t rs2, regsel_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(int imm, regsel_t rs2, regsel_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(int imm, regsel_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t next_pc();
        return 32'h100 + word_t'(4 * t_name.size());
    endfunction

    // Little-endian lane pick and extension
    function automatic word_t ld_ref(word_t a, logic [2:0] f3);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[a[7:2]];
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'b0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic add(string name, word_t instr, logic pred, int kind, regsel_t rd,
                       word_t exp, word_t maddr, logic [3:0] be, word_t brj, logic misp);
        t_pc.push_back(next_pc());
        t_name.push_back(name);
        t_instr.push_back(instr);
        t_pred.push_back(pred);
        t_kind.push_back(kind);
        t_rd.push_back(rd);
        t_exp.push_back(exp);
        t_maddr.push_back(maddr);
        t_be.push_back(be);
        t_brj.push_back(brj);
        t_misp.push_back(misp);
        if ((kind == K_WR || kind == K_LD) && rd != '0) begin
            ref_regs[rd] = exp;
            wb_expected++;
        end
    endtask

    task automatic add_wr(string name, word_t instr, regsel_t rd, word_t val);
        add(name, instr, 1'b0, K_WR, rd, val, '0, '0, next_pc() + 4, 1'b0);
    endtask

    task automatic add_st(string name, logic [2:0] f3, regsel_t rs2, regsel_t rs1, int imm);
        word_t      a, src, d;
        logic [3:0] be;
        int         size;
        a    = ref_regs[rs1] + word_t'(imm);
        src  = ref_regs[rs2];
        size = (f3 == 3'b000) ? 1 : ((f3 == 3'b001) ? 2 : 4);
        be   = '0;
        // Each lane carries the source byte at its place within the access size
        for (int b = 0; b < 4; b++) begin
            d[8*b +: 8] = src[8*(b % size) +: 8];
            if (b >= int'(a[1:0]) && b < int'(a[1:0]) + size) begin
                be[b] = 1'b1;
                ref_mem[a[7:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
        add(name, enc_s(imm, rs2, rs1, f3), 1'b0, K_ST, '0, d, a, be, next_pc() + 4, 1'b0);
    endtask

    task automatic add_ld(string name, logic [2:0] f3, regsel_t rd, regsel_t rs1, int imm);
        word_t a;
        a = ref_regs[rs1] + word_t'(imm);
        add(name, enc_i(imm, rs1, f3, rd, 7'b0000011), 1'b0, K_LD, rd, ld_ref(a, f3), a,
            '0, next_pc() + 4, 1'b0);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_wb(string name, wb_t exp, wb_t act);
        checks++;
        if (act.wen !== exp.wen || (exp.wen && act !== exp)) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_exc(string name, exc_t exp, exc_t act);
        checks++;
        if ({act.mal_l, act.mal_s, act.illegal} !== {exp.mal_l, exp.mal_s, exp.illegal} ||
            ((exp.mal_l || exp.mal_s) && act.badaddr !== exp.badaddr)) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 64; i++)
            ref_mem[i] = fill(i);
        ref_regs = '{default: '0};
        // Preload
        add_wr("addi x1", enc_i(5, 0, 0, 1, 7'b0010011), 1, 32'd5);
        add_wr("addi x2", enc_i(-8, 0, 0, 2, 7'b0010011), 2, 32'hFFFFFFF8);
        add_wr("lui x3", {20'h12345, 5'd3, 7'b0110111}, 3, 32'h12345000);
        add_wr("addi x3", enc_i(32'h678, 3, 0, 3, 7'b0010011), 3, 32'h12345678);
        add_wr("addi x4", enc_i(32'h40, 0, 0, 4, 7'b0010011), 4, 32'h40);
        // ALU
        add_wr("add", enc_r(7'h00, 2, 1, 3'b000, 5), 5, 32'hFFFFFFFD);
        add_wr("sub", enc_r(7'h20, 2, 1, 3'b000, 5), 5, 32'd13);
        add_wr("sra", enc_r(7'h20, 1, 2, 3'b101, 6), 6, 32'hFFFFFFFF);
        add_wr("srai", enc_i(32'h401, 2, 3'b101, 6, 7'b0010011), 6, 32'hFFFFFFFC);
        add_wr("srl", enc_r(7'h00, 1, 2, 3'b101, 6), 6, 32'h07FFFFFF);
        add_wr("sltu", enc_r(7'h00, 2, 1, 3'b011, 7), 7, 32'd1);
        add_wr("slt", enc_r(7'h00, 2, 1, 3'b010, 7), 7, 32'd0);
        add_wr("slli", enc_i(4, 1, 3'b001, 7, 7'b0010011), 7, 32'h50);
        add_wr("xori", enc_i(-1, 3, 3'b100, 7, 7'b0010011), 7, 32'hEDCBA987);
        add_wr("auipc", {20'h00001, 5'd8, 7'b0010111}, 8, next_pc() + 32'h1000);
        add_wr("addi x0", enc_i(1, 1, 0, 0, 7'b0010011), 0, 32'd6);
        add_wr("add x0 src", enc_r(7'h00, 1, 0, 3'b000, 9), 9, 32'd5);
        // Branches and jumps
        add("beq taken", enc_b(16, 1, 1, 3'b000), 1'b0, K_WR, 0, 0, 0, 0, next_pc() + 16, 1'b1);
        add("bne not taken", enc_b(16, 1, 1, 3'b001), 1'b0, K_WR, 0, 0, 0, 0,
            next_pc() + 4, 1'b0);
        add("blt back", enc_b(-8, 1, 2, 3'b100), 1'b1, K_WR, 0, 0, 0, 0, next_pc() - 8, 1'b0);
        add("bltu not taken", enc_b(8, 1, 2, 3'b110), 1'b1, K_WR, 0, 0, 0, 0,
            next_pc() + 4, 1'b1);
        add("jal", enc_j(32, 10), 1'b0, K_WR, 10, next_pc() + 4, 0, 0, next_pc() + 32, 1'b1);
        add("jalr", enc_i(3, 4, 0, 11, 7'b1100111), 1'b1, K_WR, 11, next_pc() + 4, 0, 0,
            32'h42, 1'b0);
        // Stores, then loads of each size
        add_st("sw", 3'b010, 3, 4, 0);
        add_st("sb", 3'b000, 2, 4, 5);
        add_st("sh", 3'b001, 2, 4, 10);
        add_ld("lw", 3'b010, 12, 4, 0);
        add_ld("lb", 3'b000, 12, 4, 5);
        add_ld("lbu", 3'b100, 12, 4, 5);
        add_ld("lh", 3'b001, 12, 4, 10);
        add_ld("lhu", 3'b101, 12, 4, 2);
        add_ld("lw fill", 3'b010, 13, 4, 64);
        // Misaligned and illegal
        add("lw mis", enc_i(2, 4, 3'b010, 14, 7'b0000011), 1'b0, K_MAL_L, 14, 0, 32'h42, 0,
            next_pc() + 4, 1'b0);
        add("sh mis", enc_s(1, 3, 4, 3'b001), 1'b0, K_MAL_S, 0, 0, 32'h41, 0,
            next_pc() + 4, 1'b0);
        add("lh mis", enc_i(3, 4, 3'b001, 14, 7'b0000011), 1'b0, K_MAL_L, 14, 0, 32'h43, 0,
            next_pc() + 4, 1'b0);
        add("illegal", 32'h0000000B, 1'b0, K_ILL, 0, 0, 0, 0, next_pc() + 4, 1'b0);
        add_wr("x14 unwritten", enc_r(7'h00, 0, 14, 3'b000, 15), 15, ref_regs[14]);
        add("halt", `HALT_INSN, 1'b0, K_HALT, 0, 0, 0, 0, next_pc() + 4, 1'b0);
    endtask

    task automatic run_entry(int i);
        string name;
        int    kind, stall;
        wb_t   exp_wb;
        exc_t  exp_exc;
        name = t_name[i];
        kind = t_kind[i];
        @(negedge CLK);
        fetch_ex = '{pc: t_pc[i], pc4: t_pc[i] + 4, instr: t_instr[i], prediction: t_pred[i]};
        in_valid = 1'b1;
        stall = (kind == K_ST || kind == K_LD) ? int'($urandom_range(3, 0)) : 0;
        dmem_ready = (stall == 0);
        #1;
        check_word({name, " brj_addr"}, t_brj[i], brj_addr);
        check_bit({name, " mispredict"}, t_misp[i], mispredict);
        check_bit({name, " ren"}, kind == K_LD, dbus.ren);
        check_bit({name, " wen"}, kind == K_ST, dbus.wen);
        if (kind == K_ST || kind == K_LD)
            check_word({name, " addr"}, t_maddr[i], dbus.addr);
        if (kind == K_ST) begin
            check_word({name, " byte_en"}, word_t'(t_be[i]), word_t'(dbus.byte_en));
            check_word({name, " wdata"}, t_exp[i], dbus.wdata);
        end
        while (stall > 0) begin
            check_bit({name, " stalled in_ready"}, 1'b0, in_ready);
            check_bit({name, " stalled wb.wen"}, 1'b0, wb.wen);
            @(negedge CLK);
            stall--;
            if (stall == 0)
                dmem_ready = 1'b1;
            #1;
        end
        check_bit({name, " in_ready"}, 1'b1, in_ready);
        exp_wb = '{rd: t_rd[i], data: t_exp[i],
                   wen: (kind == K_WR || kind == K_LD) && t_rd[i] != '0};
        check_wb({name, " wb"}, exp_wb, wb);
        exp_exc = '{mal_l: kind == K_MAL_L, mal_s: kind == K_MAL_S, illegal: kind == K_ILL,
                    badaddr: t_maddr[i]};
        check_exc({name, " exc"}, exp_exc, exc);
        @(posedge CLK);
    endtask

    initial begin
        void'($urandom(66));
        nRST = 1'b0;
        in_valid = 1'b0;
        fetch_ex = '0;
        dmem_ready = 1'b0;
        build_table();
        for (int i = 0; i < 64; i++)
            mem[i] = fill(i);
        limit = 20 * t_name.size() + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge CLK);
        check_bit("reset in_ready", 1'b0, in_ready);
        @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < t_name.size(); i++)
            run_entry(i);
        // Stage stays parked once halted
        @(negedge CLK);
        in_valid = 1'b0;
        repeat (3) begin
            #1;
            check_bit("halt flag", 1'b1, halt);
            check_bit("halted in_ready", 1'b0, in_ready);
            @(negedge CLK);
        end
        check_word("write-back count", word_t'(wb_expected), word_t'(wb_count));
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tspp_exec.f
+incdir+hdl
hdl/rv32_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_res.sv
hdl/dmem_lanes.sv
hdl/tspp_execute_stage.sv
testbench/tspp_execute_stage_chk.sv
testbench/tspp_execute_stage_tb.sv
